// ==== include/miner_defines.svh ====
////////////////////
// miner constants
// UART bit timing, job geometry and slot count
////////////////////

`ifndef MINER_DEFINES_SVH
`define MINER_DEFINES_SVH

// clock cycles per UART bit, short for simulation
`define MINER_CLKS_PER_BIT 8

// bytes per half job, a full job is twice this
`define MINER_JOB_BYTES 8

`define MINER_SLOTS 4
`define MINER_SLOT_W 2
`define MINER_BYTE_IDX_W 3

`endif

// ==== sim/miner_testdata.txt ====
// columns: 16 job bytes (0..15), then 8 result bytes
// result byte i is job byte i XOR job byte i+8
00 11 22 33 44 55 66 77 88 99 AA BB CC DD EE FF 88 88 88 88 88 88 88 88
01 02 04 08 10 20 40 80 FF FF FF FF FF FF FF FF FE FD FB F7 EF DF BF 7F
DE AD BE EF CA FE BA BE 12 34 56 78 9A BC DE F0 CC 99 E8 97 50 42 64 4E
5A 5A 5A 5A A5 A5 A5 A5 00 FF 5A A5 00 FF 5A A5 5A A5 00 FF A5 5A FF 00
13 57 9B DF 02 46 8A CE 31 75 B9 FD 21 63 A7 E5 22 22 22 22 23 25 2D 2B
01 23 45 67 89 AB CD EF FE DC BA 98 00 11 22 33 FF FF FF FF 89 BA EF DC
80 40 20 10 08 04 02 01 01 02 04 08 10 20 40 80 81 42 24 18 18 24 42 81
3C 3C C3 C3 0F F0 69 96 C3 3C 3C C3 F0 F0 96 96 FF 00 FF 00 FF 00 FF 00
11 22 33 44 55 66 77 88 1F 2E 3D 4C 5B 6A 79 87 0E 0C 0E 08 0E 0C 0E 0F
A1 B2 C3 D4 E5 F6 07 18 1A 2B 3C 4D 5E 6F 70 81 BB 99 FF 99 BB 99 77 99

// ==== sim/tb_miner.sv ====
////////////////////
// miner testbench
// UART jobs in, XOR results checked on txd
////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "miner_defines.svh"

module tb_miner;

	localparam int CLK_PERIOD  = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int BIT_CYCLES  = `MINER_CLKS_PER_BIT;
	localparam int BYTE_CYCLES = 10 * BIT_CYCLES;
	localparam int HALF        = `MINER_JOB_BYTES;
	localparam int JOB_IN      = 2 * HALF;
	localparam int LINE_LEN    = JOB_IN + HALF;
	localparam int FILE_JOBS   = 10;
	localparam int IDLE_CYCLES = 200;
	localparam int N_FULL      = `MINER_SLOTS;
	localparam int N_MIXED     = 10;
	localparam int TOTAL_JOBS  = 1 + N_FULL + N_MIXED;
	// one job in plus its result out
	localparam int JOB_CYCLES  = (JOB_IN + HALF) * BYTE_CYCLES;
	localparam int WATCHDOG_CYCLES = 2 * (TOTAL_JOBS * JOB_CYCLES + IDLE_CYCLES);

	logic        clk_i;
	logic        rst_n_i;
	logic        rxd_i;
	logic        txd_o;
	logic [7:0]  file_mem [FILE_JOBS * LINE_LEN];
	logic [7:0]  got_q [$];
	logic [7:0]  exp_q [$];
	logic [31:0] rng_state;
	int          err_cnt;
	int          test_err;
	int          frame_err;
	int          frames_seen;
	int          pass_cnt;
	int          fail_cnt;

	miner_top i_dut (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.rxd_i   (rxd_i),
		.txd_o   (txd_o)
	);

	initial clk_i = 1'b0;
	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// caller is aligned just after a rising edge
	task automatic drive_bit(input logic b);
		rxd_i = b;
		repeat (BIT_CYCLES) @(posedge clk_i);
		#DRIVE_DELAY;
	endtask

	task automatic send_byte(input logic [7:0] data);
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++)
			drive_bit(data[i]);
		drive_bit(1'b1);
	endtask

	task automatic send_job(input logic [JOB_IN*8-1:0] job, input logic [HALF*8-1:0] want);
		for (int i = 0; i < HALF; i++)
			exp_q.push_back(want[i*8 +: 8]);
		for (int i = 0; i < JOB_IN; i++)
			send_byte(job[i*8 +: 8]);
	endtask

	task automatic send_file_job(input int n);
		logic [JOB_IN*8-1:0] job;
		logic [HALF*8-1:0]   want;
		for (int i = 0; i < JOB_IN; i++)
			job[i*8 +: 8] = file_mem[n*LINE_LEN + i];
		for (int i = 0; i < HALF; i++)
			want[i*8 +: 8] = file_mem[n*LINE_LEN + JOB_IN + i];
		send_job(job, want);
	endtask

	task automatic send_random_job();
		logic [JOB_IN*8-1:0] job;
		logic [HALF*8-1:0]   want;
		for (int i = 0; i < JOB_IN; i++) begin
			rng_state = xorshift32(rng_state);
			job[i*8 +: 8] = rng_state[7:0];
		end
		// result byte i is byte i XOR byte i+8
		for (int i = 0; i < HALF; i++)
			want[i*8 +: 8] = job[i*8 +: 8] ^ job[(i+HALF)*8 +: 8];
		send_job(job, want);
	endtask

	task automatic wait_for_results(input int limit);
		int cycles;
		cycles = 0;
		while (got_q.size() < exp_q.size() && cycles < limit) begin
			@(negedge clk_i);
			cycles++;
		end
		if (got_q.size() < exp_q.size()) begin
			$display("timed out waiting for results, %0d of %0d bytes arrived",
				got_q.size(), exp_q.size());
			err_cnt++;
		end
		// quiet period so extra bytes show up
		repeat (3 * BYTE_CYCLES) @(negedge clk_i);
		@(posedge clk_i);
		#DRIVE_DELAY;
	endtask

	task automatic compare_results();
		int         n;
		logic [7:0] got;
		logic [7:0] want;
		n = 0;
		if (got_q.size() != exp_q.size()) begin
			$display("wrong number of result bytes, expected %0d, got %0d",
				exp_q.size(), got_q.size());
			err_cnt++;
		end
		while (got_q.size() > 0 && exp_q.size() > 0) begin
			got  = got_q.pop_front();
			want = exp_q.pop_front();
			if (got !== want) begin
				$display("ERROR txd_o byte %0d: expected %02h, got %02h", n, want, got);
				err_cnt++;
			end
			n++;
		end
		got_q.delete();
		exp_q.delete();
	endtask

	task automatic finish_test(input string name);
		if (err_cnt == test_err) begin
			$display("test %s: passed", name);
			pass_cnt++;
		end else begin
			$display("test %s: failed with %0d errors", name, err_cnt - test_err);
			fail_cnt++;
		end
		test_err = err_cnt;
	endtask

	// samples txd at bit midpoints on the falling edge
	initial begin : monitor
		logic [7:0] data;
		wait (rst_n_i === 1'b1);
		forever begin
			@(negedge clk_i);
			if (txd_o === 1'b0) begin
				repeat (BIT_CYCLES / 2) @(negedge clk_i);
				if (txd_o !== 1'b0) begin
					$display("ERROR txd_o start bit at %0t: expected %h, got %h",
						$time, 1'b0, txd_o);
					frame_err++;
				end
				for (int i = 0; i < 8; i++) begin
					repeat (BIT_CYCLES) @(negedge clk_i);
					data[i] = txd_o;
				end
				repeat (BIT_CYCLES) @(negedge clk_i);
				if (txd_o !== 1'b1) begin
					$display("ERROR txd_o stop bit at %0t: expected %h, got %h",
						$time, 1'b1, txd_o);
					frame_err++;
				end
				frames_seen++;
				got_q.push_back(data);
			end
		end
	end

	initial begin : main
		logic idle_bad;
		rxd_i       = 1'b1;
		rst_n_i     = 1'b0;
		rng_state   = 32'd2504;
		err_cnt     = 0;
		test_err    = 0;
		frame_err   = 0;
		frames_seen = 0;
		pass_cnt    = 0;
		fail_cnt    = 0;
		idle_bad    = 1'b0;
		$readmemh("sim/miner_testdata.txt", file_mem);
		repeat (3) @(posedge clk_i);
		#DRIVE_DELAY;
		rst_n_i = 1'b1;

		for (int i = 0; i < IDLE_CYCLES; i++) begin
			@(negedge clk_i);
			if (txd_o !== 1'b1 && !idle_bad) begin
				$display("ERROR txd_o idle cycle %0d: expected %h, got %h", i, 1'b1, txd_o);
				idle_bad = 1'b1;
				err_cnt++;
			end
		end
		if (got_q.size() != 0) begin
			$display("a byte was sent while no job was given");
			err_cnt++;
		end
		got_q.delete();
		finish_test("idle");
		@(posedge clk_i);
		#DRIVE_DELAY;

		send_file_job(0);
		wait_for_results(2 * JOB_CYCLES);
		compare_results();
		finish_test("single job");

		for (int j = 1; j <= N_FULL; j++)
			send_file_job(j);
		wait_for_results(2 * N_FULL * JOB_CYCLES);
		compare_results();
		finish_test("four jobs back to back");

		for (int j = 0; j < N_MIXED / 2; j++) begin
			send_file_job(1 + N_FULL + j);
			send_random_job();
		end
		wait_for_results(2 * N_MIXED * JOB_CYCLES);
		compare_results();
		finish_test("ten mixed jobs");

		err_cnt = err_cnt + frame_err;
		if (frames_seen != TOTAL_JOBS * HALF) begin
			$display("framing saw %0d frames instead of %0d", frames_seen, TOTAL_JOBS * HALF);
			err_cnt++;
		end
		finish_test("framing");

		$display("tests run: %0d, passed: %0d, failed: %0d",
			pass_cnt + fail_cnt, pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_i);
		$display("watchdog expired before all tests finished");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
src/miner_pkg.sv
src/uart_rx.sv
src/job_receiver.sv
src/job_bank.sv
src/result_sender.sv
src/uart_tx.sv
src/miner_top.sv
sim/tb_miner.sv

// ==== src/job_bank.sv ====
////////////////////
// job bank
// slotted byte store, registered read
////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "miner_defines.svh"

module job_bank (
	input  logic                 clk_i,
	input  logic                 wr_i,
	input  miner_pkg::slot_t     wr_slot_i,
	input  miner_pkg::byte_idx_t wr_idx_i,
	input  miner_pkg::byte_t     wr_data_i,
	input  miner_pkg::slot_t     rd_slot_i,
	input  miner_pkg::byte_idx_t rd_idx_i,
	output miner_pkg::byte_t     rd_data_o
);

	// address is {slot, byte index}
	miner_pkg::byte_t mem [`MINER_SLOTS * `MINER_JOB_BYTES];

	always_ff @(posedge clk_i) begin
		if (wr_i)
			mem[{wr_slot_i, wr_idx_i}] <= wr_data_i;
		rd_data_o <= mem[{rd_slot_i, rd_idx_i}];
	end

endmodule

`default_nettype wire

// ==== src/job_receiver.sv ====
////////////////////
// job receiver
// splits 16-byte jobs over two banks by slot
////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "miner_defines.svh"

module job_receiver (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	input  miner_pkg::byte_t     rx_byte_i,
	input  logic                 rx_en_i,
	output logic                 wr_a_o,
	output logic                 wr_b_o,
	output miner_pkg::slot_t     wr_slot_o,
	output miner_pkg::byte_idx_t wr_idx_o,
	output miner_pkg::byte_t     wr_data_o,
	output logic                 job_ready_o
);

	localparam miner_pkg::byte_idx_t IDX_LAST = miner_pkg::byte_idx_t'(`MINER_JOB_BYTES - 1);

	// top bit picks the bank, low bits the byte
	logic [`MINER_BYTE_IDX_W:0] byte_cnt;
	logic                       last_wr;

	assign last_wr = wr_b_o && (wr_idx_o == IDX_LAST);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			byte_cnt    <= '0;
			wr_a_o      <= 1'b0;
			wr_b_o      <= 1'b0;
			wr_slot_o   <= '0;
			job_ready_o <= 1'b0;
		end else begin
			wr_a_o      <= rx_en_i & ~byte_cnt[`MINER_BYTE_IDX_W];
			wr_b_o      <= rx_en_i & byte_cnt[`MINER_BYTE_IDX_W];
			job_ready_o <= last_wr;
			if (rx_en_i)
				byte_cnt <= byte_cnt + 1'b1;
			if (last_wr)
				wr_slot_o <= wr_slot_o + 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rx_en_i) begin
			wr_idx_o  <= byte_cnt[`MINER_BYTE_IDX_W-1:0];
			wr_data_o <= rx_byte_i;
		end
	end

	a_one_bank: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(wr_a_o && wr_b_o));

endmodule

`default_nettype wire

// ==== src/miner_pkg.sv ====
////////////////////
// miner package
// shared widths and FSM encodings
////////////////////

`default_nettype none
`include "miner_defines.svh"

package miner_pkg;

	typedef logic [7:0]                     byte_t;
	typedef logic [`MINER_SLOT_W-1:0]       slot_t;
	typedef logic [`MINER_BYTE_IDX_W-1:0]   byte_idx_t;
	typedef logic [3:0]                     bit_cnt_t;

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;
	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
	typedef enum logic [1:0] {SEND_IDLE, SEND_READ, SEND_LOAD, SEND_WAIT_TX} send_state_e;

endpackage

`default_nettype wire

// ==== src/miner_top.sv ====
////////////////////
// miner top
// UART in, two job banks, XOR results, UART out
////////////////////

`timescale 1ns/1ps
`default_nettype none

module miner_top (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic rxd_i,
	output logic txd_o
);

	logic                 rx_en;
	miner_pkg::byte_t     rx_byte;
	logic                 wr_a;
	logic                 wr_b;
	miner_pkg::slot_t     wr_slot;
	miner_pkg::byte_idx_t wr_idx;
	miner_pkg::byte_t     wr_data;
	logic                 job_ready;
	miner_pkg::slot_t     rd_slot;
	miner_pkg::byte_idx_t rd_idx;
	miner_pkg::byte_t     a_data;
	miner_pkg::byte_t     b_data;
	logic                 tx_en;
	miner_pkg::byte_t     tx_byte;
	logic                 tx_busy;

	uart_rx i_uart_rx (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.rxd_i     (rxd_i),
		.rx_byte_o (rx_byte),
		.rx_en_o   (rx_en)
	);

	job_receiver i_job_receiver (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.rx_byte_i   (rx_byte),
		.rx_en_i     (rx_en),
		.wr_a_o      (wr_a),
		.wr_b_o      (wr_b),
		.wr_slot_o   (wr_slot),
		.wr_idx_o    (wr_idx),
		.wr_data_o   (wr_data),
		.job_ready_o (job_ready)
	);

	// both halves share slot and byte addressing
	job_bank bank_a (
		.clk_i     (clk_i),
		.wr_i      (wr_a),
		.wr_slot_i (wr_slot),
		.wr_idx_i  (wr_idx),
		.wr_data_i (wr_data),
		.rd_slot_i (rd_slot),
		.rd_idx_i  (rd_idx),
		.rd_data_o (a_data)
	);

	job_bank bank_b (
		.clk_i     (clk_i),
		.wr_i      (wr_b),
		.wr_slot_i (wr_slot),
		.wr_idx_i  (wr_idx),
		.wr_data_i (wr_data),
		.rd_slot_i (rd_slot),
		.rd_idx_i  (rd_idx),
		.rd_data_o (b_data)
	);

	result_sender i_result_sender (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.job_ready_i (job_ready),
		.a_data_i    (a_data),
		.b_data_i    (b_data),
		.tx_busy_i   (tx_busy),
		.rd_slot_o   (rd_slot),
		.rd_idx_o    (rd_idx),
		.tx_en_o     (tx_en),
		.tx_byte_o   (tx_byte)
	);

	uart_tx i_uart_tx (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.tx_en_i   (tx_en),
		.tx_byte_i (tx_byte),
		.txd_o     (txd_o),
		.busy_o    (tx_busy)
	);

endmodule

`default_nettype wire

// ==== src/result_sender.sv ====
////////////////////
// result sender
// reads both banks, XORs byte pairs, feeds the transmitter
////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "miner_defines.svh"

module result_sender (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	input  logic                 job_ready_i,
	input  miner_pkg::byte_t     a_data_i,
	input  miner_pkg::byte_t     b_data_i,
	input  logic                 tx_busy_i,
	output miner_pkg::slot_t     rd_slot_o,
	output miner_pkg::byte_idx_t rd_idx_o,
	output logic                 tx_en_o,
	output miner_pkg::byte_t     tx_byte_o
);

	localparam miner_pkg::byte_idx_t IDX_LAST = miner_pkg::byte_idx_t'(`MINER_JOB_BYTES - 1);

	miner_pkg::send_state_e state;
	logic [`MINER_SLOT_W:0] item_cnt;
	logic                   send_last;

	// last byte of the slot goes out this cycle
	assign send_last = (state == miner_pkg::SEND_WAIT_TX) && !tx_busy_i
		&& (rd_idx_o == IDX_LAST);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			item_cnt  <= '0;
			rd_slot_o <= '0;
		end else begin
			case ({job_ready_i, send_last})
				2'b10: item_cnt <= item_cnt + 1'b1;
				2'b01: item_cnt <= item_cnt - 1'b1;
				default: item_cnt <= item_cnt;
			endcase
			if (send_last)
				rd_slot_o <= rd_slot_o + 1'b1;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state    <= miner_pkg::SEND_IDLE;
			rd_idx_o <= '0;
			tx_en_o  <= 1'b0;
		end else begin
			tx_en_o <= 1'b0;
			case (state)
				miner_pkg::SEND_IDLE: begin
					if (item_cnt != '0)
						state <= miner_pkg::SEND_READ;
				end
				// bank answers one cycle after the address
				miner_pkg::SEND_READ: state <= miner_pkg::SEND_LOAD;
				miner_pkg::SEND_LOAD: state <= miner_pkg::SEND_WAIT_TX;
				default: begin
					if (!tx_busy_i) begin
						tx_en_o  <= 1'b1;
						rd_idx_o <= rd_idx_o + 1'b1;
						state    <= send_last ? miner_pkg::SEND_IDLE : miner_pkg::SEND_READ;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state == miner_pkg::SEND_LOAD)
			tx_byte_o <= a_data_i ^ b_data_i;
	end

	// input cannot stall, so slots must never overflow
	a_item_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		item_cnt <= `MINER_SLOTS);

endmodule

`default_nettype wire

// ==== src/uart_rx.sv ====
////////////////////
// uart receiver
// 8N1 framing, samples each bit mid-period
////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "miner_defines.svh"

module uart_rx (
	input  logic             clk_i,
	input  logic             rst_n_i,
	input  logic             rxd_i,
	output miner_pkg::byte_t rx_byte_o,
	output logic             rx_en_o
);

	localparam int CNT_W = $clog2(`MINER_CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`MINER_CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`MINER_CLKS_PER_BIT / 2 - 1);

	miner_pkg::rx_state_e state;
	miner_pkg::bit_cnt_t  bit_cnt;
	miner_pkg::byte_t     shift;
	logic [1:0]           rxd_sync;
	logic                 rxd_prev;
	logic [CNT_W-1:0]     clk_cnt;
	logic                 fall;
	logic                 data_tick;
	logic                 stop_ok;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rxd_sync <= 2'b11;
			rxd_prev <= 1'b1;
		end else begin
			rxd_sync <= {rxd_sync[0], rxd_i};
			rxd_prev <= rxd_sync[1];
		end
	end

	assign fall      = rxd_prev & ~rxd_sync[1];
	assign data_tick = (state == miner_pkg::RX_DATA) && (clk_cnt == BIT_LAST);
	assign stop_ok   = (state == miner_pkg::RX_STOP) && (clk_cnt == BIT_LAST) && rxd_sync[1];

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state   <= miner_pkg::RX_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			rx_en_o <= 1'b0;
		end else begin
			rx_en_o <= stop_ok;
			clk_cnt <= clk_cnt + 1'b1;
			case (state)
				miner_pkg::RX_IDLE: begin
					clk_cnt <= '0;
					if (fall)
						state <= miner_pkg::RX_START;
				end
				miner_pkg::RX_START: begin
					// recheck the line half a bit after the edge
					if (clk_cnt == HALF_LAST) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						state   <= rxd_sync[1] ? miner_pkg::RX_IDLE : miner_pkg::RX_DATA;
					end
				end
				miner_pkg::RX_DATA: begin
					if (data_tick) begin
						clk_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 4'd7)
							state <= miner_pkg::RX_STOP;
					end
				end
				default: begin
					// low stop bit drops the frame
					if (clk_cnt == BIT_LAST)
						state <= miner_pkg::RX_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (data_tick)
			shift <= {rxd_sync[1], shift[7:1]};
		if (stop_ok)
			rx_byte_o <= shift;
	end

	a_rx_en_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		rx_en_o |=> !rx_en_o);

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
////////////////////
// uart transmitter
// 8N1 framing, LSB first
////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "miner_defines.svh"

module uart_tx (
	input  logic             clk_i,
	input  logic             rst_n_i,
	input  logic             tx_en_i,
	input  miner_pkg::byte_t tx_byte_i,
	output logic             txd_o,
	output logic             busy_o
);

	localparam int CNT_W = $clog2(`MINER_CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`MINER_CLKS_PER_BIT - 1);

	miner_pkg::tx_state_e state;
	miner_pkg::bit_cnt_t  bit_cnt;
	miner_pkg::byte_t     shift;
	logic [CNT_W-1:0]     clk_cnt;
	logic                 bit_end;

	assign bit_end = (clk_cnt == BIT_LAST);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state   <= miner_pkg::TX_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			txd_o   <= 1'b1;
			busy_o  <= 1'b0;
		end else begin
			clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
			case (state)
				miner_pkg::TX_IDLE: begin
					clk_cnt <= '0;
					if (tx_en_i) begin
						busy_o <= 1'b1;
						txd_o  <= 1'b0;
						state  <= miner_pkg::TX_START;
					end
				end
				miner_pkg::TX_START: begin
					if (bit_end) begin
						txd_o   <= shift[0];
						bit_cnt <= '0;
						state   <= miner_pkg::TX_DATA;
					end
				end
				miner_pkg::TX_DATA: begin
					if (bit_end) begin
						bit_cnt <= bit_cnt + 1'b1;
						txd_o   <= (bit_cnt == 4'd7) ? 1'b1 : shift[1];
						if (bit_cnt == 4'd7)
							state <= miner_pkg::TX_STOP;
					end
				end
				default: begin
					if (bit_end) begin
						busy_o <= 1'b0;
						state  <= miner_pkg::TX_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state == miner_pkg::TX_IDLE && tx_en_i)
			shift <= tx_byte_i;
		else if (state == miner_pkg::TX_DATA && bit_end)
			shift <= {1'b0, shift[7:1]};
	end

	a_no_overrun: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		tx_en_i |-> !busy_o);

endmodule

`default_nettype wire
